/* logic/dual_issue_pkg.sv */
package dual_issue_pkg;

  localparam int inst_width = 32;
  localparam int opcode_msb = 31;
  localparam int opcode_lsb = 26;
  localparam int opcode_width = opcode_msb - opcode_lsb + 1;

  typedef enum logic [opcode_width-1:0] {
    op_nop   = 6'b00_0000,
    op_add   = 6'b00_0001,
    op_sub   = 6'b00_0010,
    op_cmp   = 6'b00_0011,
    op_test  = 6'b00_0100,
    op_addi  = 6'b01_0001,
    op_subi  = 6'b01_0010,
    op_cmpi  = 6'b01_0011,
    op_testi = 6'b01_0100,
    op_lw    = 6'b10_0000,
    op_sw    = 6'b10_0001,
    op_la    = 6'b10_0010,
    op_sa    = 6'b10_0011,
    op_jmp   = 6'b11_0000,
    op_je    = 6'b11_0001,
    op_jo    = 6'b11_0010
  } op_code_e;

  typedef enum logic [1:0] {
    pipe_any    = 2'd0,
    pipe_branch = 2'd1, // pipe a only.
    pipe_memory = 2'd2  // pipe b only.
  } pipe_class_e;

  localparam logic [inst_width-1:0] nop_inst = '0;

  typedef struct packed {
    logic [inst_width-1:0] inst0; // older.
    logic [inst_width-1:0] inst1; // younger.
  } inst_pair_t;

  typedef struct packed {
    logic [inst_width-1:0] slot_a;
    logic [inst_width-1:0] slot_b;
    logic                  older_in_b;
  } issue_bundle_t;

  // Pipe class from the top two opcode bits, with compares and tests
  // in the register and immediate groups forced to the branch pipe.
  function automatic pipe_class_e classify_op(input logic [opcode_width-1:0] op);
    pipe_class_e cls;
    unique case (op[opcode_width-1 -: 2])
      2'b00, 2'b01: begin
        if (op == op_cmp || op == op_test || op == op_cmpi || op == op_testi) begin
          cls = pipe_branch;
        end else begin
          cls = pipe_any; // includes the all-zero nop.
        end
      end
      2'b10: cls = pipe_memory;
      default: cls = pipe_branch;
    endcase
    return cls;
  endfunction

  function automatic pipe_class_e classify_inst(input logic [inst_width-1:0] inst);
    return classify_op(inst[opcode_msb:opcode_lsb]);
  endfunction

endpackage

/* logic/fetch_pair_buffer.sv */
`timescale 1ns/1ps

module fetch_pair_buffer
  import dual_issue_pkg::*;
#(
  parameter int pair_depth = 4
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  inst_pair_t push_pair,
  input  logic       pop,
  output inst_pair_t head,
  output logic       empty,
  output logic       full
);

  localparam int ptr_width = $clog2(pair_depth);
  localparam int cnt_width = ptr_width + 1;

  inst_pair_t           mem [pair_depth];
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [cnt_width-1:0] count;
  logic                 do_push;
  logic                 do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // pair storage.
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_pair;
    end
  end

  // pointers wrap at the power-of-two depth.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
    end else if (do_push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_ptr <= '0;
    end else if (do_pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      unique case ({do_push, do_pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count; // none or both.
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == cnt_width'(pair_depth));

  initial begin
    assert (pair_depth >= 2 && (pair_depth & (pair_depth - 1)) == 0)
      else $error("pair_depth must be a power of two from 2 upward");
  end

  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n)
    push |-> !full
  ) else $error("push while buffer full");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n)
    pop |-> !empty
  ) else $error("pop while buffer empty");

endmodule

/* logic/issue_steer.sv */
`timescale 1ns/1ps

module issue_steer
  import dual_issue_pkg::*;
(
  input  logic          clk,
  input  logic          arst_n,
  input  inst_pair_t    head,
  input  logic          empty,
  input  logic          hold,
  output logic          pop,
  output logic          issue_valid,
  output issue_bundle_t issue
);

  pipe_class_e   cls0;
  pipe_class_e   cls1;
  logic          accept;
  logic          split;
  logic          phase2;
  issue_bundle_t next_bundle;

  // both instructions take the same classification path.
  assign cls0 = classify_op(head.inst0[opcode_msb:opcode_lsb]);
  assign cls1 = classify_op(head.inst1[opcode_msb:opcode_lsb]);

  assign accept = !empty && !hold;
  assign split  = (cls0 == cls1) && (cls0 != pipe_any);

  // final issue of the head pops it.
  assign pop = accept && (!split || phase2);

  always_comb begin
    next_bundle.slot_a     = head.inst0;
    next_bundle.slot_b     = head.inst1;
    next_bundle.older_in_b = 1'b0;
    unique case ({cls0, cls1})
      {pipe_branch, pipe_branch}: begin
        next_bundle.slot_a = phase2 ? head.inst1 : head.inst0;
        next_bundle.slot_b = nop_inst;
      end
      {pipe_memory, pipe_memory}: begin
        next_bundle.slot_a     = nop_inst;
        next_bundle.slot_b     = phase2 ? head.inst1 : head.inst0;
        next_bundle.older_in_b = 1'b1;
      end
      {pipe_memory, pipe_branch},
      {pipe_memory, pipe_any},
      {pipe_any, pipe_branch}: begin
        next_bundle.slot_a     = head.inst1; // swapped.
        next_bundle.slot_b     = head.inst0;
        next_bundle.older_in_b = 1'b1;
      end
      default: begin
        next_bundle.slot_a     = head.inst0;
        next_bundle.slot_b     = head.inst1;
        next_bundle.older_in_b = 1'b0;
      end
    endcase
  end

  // second half of a split pair pending.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      phase2 <= 1'b0;
    end else if (accept) begin
      phase2 <= split && !phase2;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue_valid <= 1'b0;
    end else begin
      issue_valid <= accept;
    end
  end

  // bundle keeps its value while held.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      issue <= '0;
    end else if (accept) begin
      issue <= next_bundle;
    end
  end

  a_slot_a_no_memory: assert property (
    @(posedge clk) disable iff (!arst_n)
    issue_valid |-> classify_inst(issue.slot_a) != pipe_memory
  ) else $error("memory instruction issued in slot a");

  a_slot_b_no_branch: assert property (
    @(posedge clk) disable iff (!arst_n)
    issue_valid |-> classify_inst(issue.slot_b) != pipe_branch
  ) else $error("branch instruction issued in slot b");

  // the split pair must stay at the head until its second issue.
  a_phase2_head_kept: assert property (
    @(posedge clk) disable iff (!arst_n)
    phase2 |-> !empty && $stable(head)
  ) else $error("head lost during split issue");

endmodule

/* logic/dual_issue_front.sv */
`timescale 1ns/1ps

module dual_issue_front
  import dual_issue_pkg::*;
#(
  parameter int pair_depth = 4
) (
  input  logic          clk,
  input  logic          arst_n,
  input  logic          push,
  input  inst_pair_t    push_pair,
  input  logic          hold,
  output logic          full,
  output logic          issue_valid,
  output issue_bundle_t issue
);

  inst_pair_t head;
  logic       empty;
  logic       pop;

  fetch_pair_buffer #(
    .pair_depth (pair_depth)
  ) u_buffer (
    .clk       (clk),
    .arst_n    (arst_n),
    .push      (push),
    .push_pair (push_pair),
    .pop       (pop),
    .head      (head),
    .empty     (empty),
    .full      (full)
  );

  issue_steer u_steer (
    .clk         (clk),
    .arst_n      (arst_n),
    .head        (head),
    .empty       (empty),
    .hold        (hold),
    .pop         (pop),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

endmodule

/* tests/steer_model.svh */
`ifndef steer_model_svh
`define steer_model_svh

typedef struct packed {
  issue_bundle_t bundle;
  logic          final_issue; // the pair leaves the buffer here.
} expect_t;

// pipe class listed per opcode.
function automatic pipe_class_e expected_class(input logic [inst_width-1:0] inst);
  pipe_class_e cls;
  case (inst[opcode_msb:opcode_lsb])
    op_cmp, op_test, op_cmpi, op_testi: cls = pipe_branch;
    op_jmp, op_je, op_jo: cls = pipe_branch;
    op_lw, op_sw, op_la, op_sa: cls = pipe_memory;
    default: cls = pipe_any; // nop and plain alu work.
  endcase
  return cls;
endfunction

function automatic expect_t make_expect(
  input logic [inst_width-1:0] slot_a,
  input logic [inst_width-1:0] slot_b,
  input logic                  older_in_b,
  input logic                  final_issue
);
  expect_t e;
  e.bundle.slot_a     = slot_a;
  e.bundle.slot_b     = slot_b;
  e.bundle.older_in_b = older_in_b;
  e.final_issue       = final_issue;
  return e;
endfunction

// one pushed pair gives one or two bundles, returns how many.
function automatic int expand_pair(
  input  inst_pair_t p,
  output expect_t    bundle_1,
  output expect_t    bundle_2
);
  pipe_class_e c0;
  pipe_class_e c1;
  c0 = expected_class(p.inst0);
  c1 = expected_class(p.inst1);
  bundle_2 = '0;
  if (c0 == pipe_branch && c1 == pipe_branch) begin
    bundle_1 = make_expect(p.inst0, nop_inst, 1'b0, 1'b0);
    bundle_2 = make_expect(p.inst1, nop_inst, 1'b0, 1'b1);
    return 2;
  end
  if (c0 == pipe_memory && c1 == pipe_memory) begin
    bundle_1 = make_expect(nop_inst, p.inst0, 1'b1, 1'b0);
    bundle_2 = make_expect(nop_inst, p.inst1, 1'b1, 1'b1);
    return 2;
  end
  if (c0 == pipe_memory || (c0 == pipe_any && c1 == pipe_branch)) begin
    bundle_1 = make_expect(p.inst1, p.inst0, 1'b1, 1'b1); // swapped.
    return 1;
  end
  bundle_1 = make_expect(p.inst0, p.inst1, 1'b0, 1'b1);
  return 1;
endfunction

`endif

/* tests/dual_issue_front_tb.sv */
`timescale 1ns/1ps

module dual_issue_front_tb
  import dual_issue_pkg::*;
();

  localparam int tb_depth = 4;
  localparam int random_pairs = 300;

  `include "steer_model.svh"

  logic          clk;
  logic          arst_n;
  logic          push;
  inst_pair_t    push_pair;
  logic          hold;
  logic          full;
  logic          issue_valid;
  issue_bundle_t issue;

  expect_t       expected_q[$];
  expect_t       exp_head = '0;
  int            exp_count = 0;
  int            pushed_cnt = 0;
  int            popped_cnt = 0;
  int            occupancy;
  int            depth = 0;
  int            cycles = 0;
  int            compare_errors = 0;
  int            check_errors = 0;
  op_code_e      all_ops[$];

  dual_issue_front #(
    .pair_depth (tb_depth)
  ) dut0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (push),
    .push_pair   (push_pair),
    .hold        (hold),
    .full        (full),
    .issue_valid (issue_valid),
    .issue       (issue)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // scoreboard queue fed with pre-edge dut values.
  always @(posedge clk) begin
    expect_t e1;
    expect_t e2;
    int      n;
    if (arst_n) begin
      if (issue_valid && expected_q.size() != 0) begin
        if (expected_q[0].final_issue) popped_cnt++;
        void'(expected_q.pop_front());
      end
      if (push && !full) begin
        n = expand_pair(push_pair, e1, e2);
        expected_q.push_back(e1);
        if (n == 2) expected_q.push_back(e2);
        pushed_cnt++;
      end
      exp_count = expected_q.size();
      exp_head  = (exp_count != 0) ? expected_q[0] : '0;
    end
  end

  // buffered pairs less a final issue now on the output.
  always_comb begin
    occupancy = pushed_cnt - popped_cnt - int'(issue_valid && exp_head.final_issue);
  end

  a_issue_matches: assert property (
    @(posedge clk) disable iff (!arst_n)
    (issue_valid && exp_count != 0) |-> issue == exp_head.bundle
  ) else begin
    compare_errors++;
    $display("** Error at %0t: issue bundle mismatch, expected %h, got %h",
             $time, $sampled(exp_head.bundle), $sampled(issue));
  end

  a_no_spurious_issue: assert property (
    @(posedge clk) disable iff (!arst_n)
    (exp_count == 0) |-> !issue_valid
  ) else begin
    check_errors++;
    $display("issue_valid was high at %0t with nothing expected", $time);
  end

  a_idle_after_reset: assert property (
    @(posedge clk) disable iff (!arst_n)
    (pushed_cnt == 0) |-> !issue_valid && !full && issue == '0
  ) else begin
    check_errors++;
    $display("outputs were not idle after reset at %0t", $time);
  end

  a_hold_blocks_issue: assert property (
    @(posedge clk) disable iff (!arst_n)
    hold |=> !issue_valid
  ) else begin
    check_errors++;
    $display("a bundle issued after a held cycle at %0t", $time);
  end

  a_full_level: assert property (
    @(posedge clk) disable iff (!arst_n)
    full == (occupancy == depth)
  ) else begin
    check_errors++;
    $display("full did not match %0d unpopped pairs at %0t", $sampled(occupancy), $time);
  end

  task automatic print_error_counts();
    $display("errors: compare %0d, other %0d", compare_errors, check_errors);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > 20 * pushed_cnt + 200) begin
      $display("timeout: the run did not finish within %0d cycles", cycles - 1);
      print_error_counts();
      $display("RESULT: FAIL");
      $finish;
    end
  end

  task automatic wait_edge();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [inst_width-1:0] make_inst(input op_code_e op);
    logic [opcode_lsb-1:0] operands;
    operands = opcode_lsb'($urandom);
    return {op, operands};
  endfunction

  function automatic inst_pair_t random_pair();
    inst_pair_t p;
    p.inst0 = make_inst(all_ops[$urandom_range(all_ops.size() - 1)]);
    p.inst1 = make_inst(all_ops[$urandom_range(all_ops.size() - 1)]);
    return p;
  endfunction

  task automatic push_one(input inst_pair_t p);
    while (full) wait_edge();
    push      = 1'b1;
    push_pair = p;
    wait_edge();
    push      = 1'b0;
  endtask

  task automatic send_ops(input op_code_e op0, input op_code_e op1);
    inst_pair_t p;
    p.inst0 = make_inst(op0);
    p.inst1 = make_inst(op1);
    push_one(p);
  endtask

  task automatic drain();
    hold = 1'b0;
    while (expected_q.size() != 0) wait_edge();
    repeat (2) wait_edge();
  endtask

  initial begin
    op_code_e op;
    int       sent;
    void'($urandom(32'h553360f1));
    depth     = dut0.pair_depth;
    arst_n    = 1'b0;
    push      = 1'b0;
    push_pair = '0;
    hold      = 1'b0;
    op = op.first();
    do begin
      all_ops.push_back(op);
      op = op.next();
    end while (op != op.first());
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    repeat (4) wait_edge(); // nothing pushed yet.

    // pass-through.
    send_ops(op_add, op_subi);
    send_ops(op_nop, op_nop);
    send_ops(op_cmp, op_lw);
    send_ops(op_cmpi, op_sw);
    send_ops(op_je, op_add);
    send_ops(op_testi, op_addi);
    send_ops(op_addi, op_sw);
    drain();

    // swapping.
    send_ops(op_lw, op_jmp);
    send_ops(op_la, op_cmpi);
    send_ops(op_sw, op_test);
    send_ops(op_sa, op_sub);
    send_ops(op_lw, op_nop);
    send_ops(op_add, op_cmp);
    send_ops(op_subi, op_testi);
    send_ops(op_nop, op_jo);
    drain();

    // split issue.
    send_ops(op_jmp, op_je);
    send_ops(op_cmp, op_testi);
    send_ops(op_lw, op_sw);
    send_ops(op_la, op_sa);
    drain();

    // fill under hold with a split pair at the head.
    hold = 1'b1;
    send_ops(op_jo, op_cmp);
    while (!full) push_one(random_pair());
    repeat (3) wait_edge();
    hold = 1'b0;
    wait_edge(); // first half only.
    hold = 1'b1;
    repeat (5) wait_edge();
    drain();

    sent = 0;
    while (sent < random_pairs) begin
      hold = ($urandom_range(3) == 0);
      if (!full && $urandom_range(2) != 0) begin
        push      = 1'b1;
        push_pair = random_pair();
        sent++;
      end else begin
        push = 1'b0;
      end
      wait_edge();
    end
    push = 1'b0;
    drain();

    print_error_counts();
    if (compare_errors + check_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dual_issue_front.f */
+incdir+tests
logic/dual_issue_pkg.sv
logic/fetch_pair_buffer.sv
logic/issue_steer.sv
logic/dual_issue_front.sv
tests/dual_issue_front_tb.sv

/* Bender.yml */
package:
  name: dual_issue_front

sources:
  - logic/dual_issue_pkg.sv
  - logic/fetch_pair_buffer.sv
  - logic/issue_steer.sv
  - logic/dual_issue_front.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/dual_issue_front_tb.sv
